// File: sources.f
+incdir+hdl
hdl/tagged_stream_pkg.sv
hdl/tagged_skid_buffer.sv
hdl/tagged_duplicator.sv
hdl/tag_filter.sv
hdl/tagged_fanout_top.sv
testbench/tagged_fanout_assertions.sv
testbench/tagged_fanout_tb.sv

// File: testbench/tagged_fanout_tb.sv
`include "tagged_stream_macros.svh"

module tagged_fanout_tb;
    import tagged_stream_pkg::*;

    localparam int NUM_STREAMS     = `NUM_STREAMS;
    localparam int NUM_SKID_STAGES = `NUM_SKID_STAGES;
    localparam int MASK_W          = 1 << `TAG_WIDTH;
    localparam int CHAIN_DEPTH     = 2 * NUM_SKID_STAGES; // elements one output chain can hold
    localparam int NUM_TESTS       = 5;
    localparam int TABLE_LEN       = 80;
    localparam int STALL_CYCLES    = 30;
    localparam int TIMEOUT         = (TABLE_LEN * 2 * NUM_SKID_STAGES + 200) * 8;

    localparam int MODE_READY  = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_STALL  = 2; // output 0 holds ready low for a while

    typedef struct packed {
        logic [1:0]                         mode;
        logic [NUM_STREAMS-1:0][MASK_W-1:0] masks;
        data_t                              data;
        tag_t                               tag;
        keep_t                              keep;
        logic                               last;
    } stim_t;

    logic              clk;
    logic              reset_synced;
    data_t             in_data;
    tag_t              in_tag;
    keep_t             in_keep;
    logic              in_last;
    logic              in_valid;
    logic              in_ready;
    logic [MASK_W-1:0] accept_mask [NUM_STREAMS];
    data_t             out_data    [NUM_STREAMS];
    tag_t              out_tag     [NUM_STREAMS];
    keep_t             out_keep    [NUM_STREAMS];
    logic              out_last    [NUM_STREAMS];
    logic              out_valid   [NUM_STREAMS];
    logic              out_ready   [NUM_STREAMS];

    stim_t tbl        [TABLE_LEN];
    string test_name  [NUM_TESTS] = '{"reset", "broadcast", "tag filter", "random ready", "stall"};
    int    test_len   [NUM_TESTS] = '{0, 12, 16, 40, 12};
    int    test_mode  [NUM_TESTS] = '{MODE_READY, MODE_READY, MODE_READY, MODE_RANDOM,
                                     MODE_STALL};
    int    test_first [NUM_TESTS];

    integer seed         = 75120;
    int     error_count  = 0;
    int     tests_failed = 0;
    int     cur_mode     = MODE_READY;
    logic   stall_hold   = 1'b0;
    int     cycle        = 0;
    int     in_count     = 0; // input transfers so far and the table index of the next one
    int     xfer_cycle [TABLE_LEN];
    int     pending    [NUM_STREAMS];
    int     exp_q      [NUM_STREAMS][$];

    tagged_fanout_top #(
        .NUM_STREAMS     (NUM_STREAMS),
        .NUM_SKID_STAGES (NUM_SKID_STAGES)
    ) dut_i (
        .clk          (clk),
        .reset_synced (reset_synced),
        .in_data      (in_data),
        .in_tag       (in_tag),
        .in_keep      (in_keep),
        .in_last      (in_last),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .accept_mask  (accept_mask),
        .out_data     (out_data),
        .out_tag      (out_tag),
        .out_keep     (out_keep),
        .out_last     (out_last),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("Error: the run timed out after %0d time units, a stream never finished",
                 TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // mismatches seen by the testbench plus failures of the bound assertions
    function automatic int total_errors();
        return error_count + dut_i.assertions_i.fail_count;
    endfunction

    // fixed subscriptions for the filter test where tags 4 and 6 match no output
    function automatic logic [MASK_W-1:0] filter_mask(input int s);
        case (s % 3)
            0:       return MASK_W'(8'h0f);
            1:       return MASK_W'(8'haa);
            default: return MASK_W'(8'h01);
        endcase
    endfunction

    function automatic bit queues_empty();
        for (int s = 0; s < NUM_STREAMS; s++) begin
            if (exp_q[s].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic build_table();
        int idx;
        int t;
        int k;
        int s;
        idx = 0;
        test_first[0] = 0;
        for (t = 1; t < NUM_TESTS; t++) begin
            test_first[t] = idx;
            for (k = 0; k < test_len[t]; k++) begin
                tbl[idx].mode = test_mode[t];
                tbl[idx].data = data_t'($random(seed));
                tbl[idx].keep = keep_t'($random(seed));
                tbl[idx].last = (k % 4 == 3) || (k == test_len[t] - 1);
                if (t == 2) begin
                    tbl[idx].tag = tag_t'(k); // walk through every tag value
                end else begin
                    tbl[idx].tag = tag_t'($random(seed));
                end
                for (s = 0; s < NUM_STREAMS; s++) begin
                    case (t)
                        2:       tbl[idx].masks[s] = filter_mask(s);
                        3:       tbl[idx].masks[s] = MASK_W'($random(seed));
                        default: tbl[idx].masks[s] = '1;
                    endcase
                end
                idx++;
            end
        end
    endtask

    task automatic send_elements(input int first, input int len);
        int k;
        int s;
        int idx;
        for (k = 0; k < len; k++) begin
            idx = first + k;
            in_data  <= tbl[idx].data;
            in_tag   <= tbl[idx].tag;
            in_keep  <= tbl[idx].keep;
            in_last  <= tbl[idx].last;
            for (s = 0; s < NUM_STREAMS; s++) begin
                accept_mask[s] <= tbl[idx].masks[s];
            end
            in_valid <= 1'b1;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk); // element stays on the input until it is taken
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic hold_stall(input int t, input int base_count);
        if (test_mode[t] == MODE_STALL) begin
            repeat (STALL_CYCLES) @(posedge clk);
            // output 0 chain is full, so the input has to be stuck by now
            check_value("input transfers during stall", CHAIN_DEPTH, in_count - base_count);
            stall_hold <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        do begin
            @(negedge clk);
        end while (!queues_empty());
        repeat (CHAIN_DEPTH) @(posedge clk); // quiet period catches stray extra elements
    endtask

    task automatic run_test(input int t);
        int k;
        int s;
        int idx;
        int base_count;
        for (k = 0; k < test_len[t]; k++) begin
            idx = test_first[t] + k;
            for (s = 0; s < NUM_STREAMS; s++) begin
                if (tbl[idx].masks[s][tbl[idx].tag]) begin
                    exp_q[s].push_back(idx);
                end
            end
        end
        cur_mode   <= test_mode[t];
        stall_hold <= (test_mode[t] == MODE_STALL);
        @(posedge clk); // sinks switch to the new ready pattern before data starts
        base_count = in_count;
        fork
            send_elements(test_first[t], test_len[t]);
            hold_stall(t, base_count);
        join
        wait_drain();
    endtask

    task automatic report_test(input int t, input int base_err);
        if (total_errors() == base_err) begin
            $display("test %0d (%s) finished with no errors", t, test_name[t]);
        end else begin
            $display("test %0d (%s) finished with %0d errors", t, test_name[t],
                     total_errors() - base_err);
            tests_failed++;
        end
    endtask

    // sink ready per output
    always @(posedge clk) begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            case (cur_mode)
                MODE_RANDOM: out_ready[s] <= (($random(seed) & 3) != 0);
                MODE_STALL:  out_ready[s] <= (s == 0) ? !stall_hold : 1'b1;
                default:     out_ready[s] <= 1'b1;
            endcase
        end
    end

    always @(posedge clk) begin : monitor
        int idx;
        int inc;
        int dec;
        if (reset_synced) begin
            cycle <= cycle + 1;
            if (in_valid && in_ready) begin
                xfer_cycle[in_count] <= cycle;
                in_count             <= in_count + 1;
            end
            for (int s = 0; s < NUM_STREAMS; s++) begin
                inc = 0;
                dec = 0;
                if (in_valid && in_ready && tbl[in_count].masks[s][tbl[in_count].tag]) begin
                    inc = 1;
                end
                if (out_valid[s] && out_ready[s]) begin
                    dec = 1;
                    if (exp_q[s].size() == 0) begin
                        $display("Error at time %0t: output %0d got an unexpected element",
                                 $time, s);
                        error_count++;
                    end else begin
                        idx = exp_q[s].pop_front();
                        check_value($sformatf("out_data[%0d]", s), tbl[idx].data, out_data[s]);
                        check_value($sformatf("out_tag[%0d]", s), tbl[idx].tag, out_tag[s]);
                        check_value($sformatf("out_keep[%0d]", s), tbl[idx].keep, out_keep[s]);
                        check_value($sformatf("out_last[%0d]", s), tbl[idx].last, out_last[s]);
                        if (tbl[idx].mode == MODE_READY) begin
                            check_value($sformatf("latency of output %0d", s), NUM_SKID_STAGES,
                                        cycle - xfer_cycle[idx]);
                        end
                    end
                end
                if (pending[s] > CHAIN_DEPTH) begin
                    $display("Error at time %0t: too many elements (%0d) in output %0d chain",
                             $time, pending[s], s);
                    error_count++;
                end
                pending[s] <= pending[s] + inc - dec;
            end
        end
    end

    initial begin
        int base_err;
        reset_synced = 1'b0;
        in_data      = '0;
        in_tag       = '0;
        in_keep      = '0;
        in_last      = 1'b0;
        in_valid     = 1'b0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            accept_mask[s] = '0;
            out_ready[s]   = 1'b1;
        end
        build_table();

        repeat (16) @(posedge clk);
        reset_synced <= 1'b1;
        @(posedge clk);

        // first cycle out of reset with nothing offered
        base_err = total_errors();
        check_value("in_ready", 1'b1, in_ready);
        for (int s = 0; s < NUM_STREAMS; s++) begin
            check_value($sformatf("out_valid[%0d]", s), 1'b0, out_valid[s]);
        end
        report_test(0, base_err);

        for (int t = 1; t < NUM_TESTS; t++) begin
            base_err = total_errors();
            run_test(t);
            report_test(t, base_err);
        end

        $display("summary: %0d tests run, %0d tests failed, %0d errors in total",
                 NUM_TESTS, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/tagged_fanout_assertions.sv
`include "tagged_stream_macros.svh"

module tagged_fanout_assertions #(
    parameter int NUM_STREAMS = `NUM_STREAMS
) (
    input logic                     clk,
    input logic                     reset_synced,

    input logic                     in_valid,
    input logic                     in_ready,
    input logic [NUM_STREAMS-1:0]   dup_valid,
    input logic [NUM_STREAMS-1:0]   filt_ready,

    input tagged_stream_pkg::data_t out_data  [NUM_STREAMS],
    input tagged_stream_pkg::tag_t  out_tag   [NUM_STREAMS],
    input tagged_stream_pkg::keep_t out_keep  [NUM_STREAMS],
    input logic                     out_last  [NUM_STREAMS],
    input logic                     out_valid [NUM_STREAMS],
    input logic                     out_ready [NUM_STREAMS]
);

    int fail_count = 0;

    // dup_valid is high only for outputs that have not taken the element yet
    a_input_blocked: assert property (@(posedge clk) disable iff (!reset_synced)
        (in_valid && |(dup_valid & ~filt_ready)) |-> !in_ready)
        else begin
            $error("input ready high while an output still owes the current element");
            fail_count++;
        end

    for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_out
        a_hold_payload: assert property (@(posedge clk) disable iff (!reset_synced)
            (out_valid[s] && !out_ready[s]) |=>
                (out_valid[s] && $stable({out_data[s], out_tag[s], out_keep[s], out_last[s]})))
            else begin
                $error("output %0d dropped valid or changed payload while stalled", s);
                fail_count++;
            end

        // the chains come out of reset empty
        a_idle_after_reset: assert property (@(posedge clk)
            !reset_synced |=> !out_valid[s])
            else begin
                $error("output %0d valid in the cycle after reset", s);
                fail_count++;
            end
    end

endmodule

bind tagged_fanout_top tagged_fanout_assertions #(
    .NUM_STREAMS (NUM_STREAMS)
) assertions_i (
    .clk          (clk),
    .reset_synced (reset_synced),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .dup_valid    (dup_valid),
    .filt_ready   (filt_ready),
    .out_data     (out_data),
    .out_tag      (out_tag),
    .out_keep     (out_keep),
    .out_last     (out_last),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
);

// File: hdl/tagged_fanout_top.sv
`include "tagged_stream_macros.svh"

module tagged_fanout_top #(
    parameter int NUM_STREAMS     = `NUM_STREAMS,
    parameter int NUM_SKID_STAGES = `NUM_SKID_STAGES
) (
    input  logic                         clk,
    input  logic                         reset_synced,

    input  tagged_stream_pkg::data_t     in_data,
    input  tagged_stream_pkg::tag_t      in_tag,
    input  tagged_stream_pkg::keep_t     in_keep,
    input  logic                         in_last,
    input  logic                         in_valid,
    output logic                         in_ready,

    input  logic [(1 << `TAG_WIDTH)-1:0] accept_mask [NUM_STREAMS],

    output tagged_stream_pkg::data_t     out_data    [NUM_STREAMS],
    output tagged_stream_pkg::tag_t      out_tag     [NUM_STREAMS],
    output tagged_stream_pkg::keep_t     out_keep    [NUM_STREAMS],
    output logic                         out_last    [NUM_STREAMS],
    output logic                         out_valid   [NUM_STREAMS],
    input  logic                         out_ready   [NUM_STREAMS]
);
    import tagged_stream_pkg::*;

    logic [NUM_STREAMS-1:0] dup_valid;
    logic [NUM_STREAMS-1:0] filt_ready;

    // index 0 is the chain head fed by the filter, the last index is the output
    data_t chain_data  [NUM_STREAMS][NUM_SKID_STAGES+1];
    tag_t  chain_tag   [NUM_STREAMS][NUM_SKID_STAGES+1];
    keep_t chain_keep  [NUM_STREAMS][NUM_SKID_STAGES+1];
    logic  chain_last  [NUM_STREAMS][NUM_SKID_STAGES+1];
    logic  chain_valid [NUM_STREAMS][NUM_SKID_STAGES+1];
    logic  chain_ready [NUM_STREAMS][NUM_SKID_STAGES+1];

    tagged_duplicator #(
        .NUM_STREAMS (NUM_STREAMS)
    ) duplicator_i (
        .clk          (clk),
        .reset_synced (reset_synced),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .dup_valid    (dup_valid),
        .dup_ready    (filt_ready)
    );

    for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_stream
        tag_filter filter_i (
            .in_valid    (dup_valid[s]),
            .in_tag      (in_tag),
            .in_ready    (filt_ready[s]),
            .accept_mask (accept_mask[s]),
            .out_valid   (chain_valid[s][0]),
            .out_ready   (chain_ready[s][0])
        );

        // payload skips the filter and goes straight into the chain head
        assign chain_data[s][0] = in_data;
        assign chain_tag[s][0]  = in_tag;
        assign chain_keep[s][0] = in_keep;
        assign chain_last[s][0] = in_last;

        for (genvar k = 0; k < NUM_SKID_STAGES; k++) begin : g_skid
            tagged_skid_buffer skid_i (
                .clk          (clk),
                .reset_synced (reset_synced),
                .in_data      (chain_data[s][k]),
                .in_tag       (chain_tag[s][k]),
                .in_keep      (chain_keep[s][k]),
                .in_last      (chain_last[s][k]),
                .in_valid     (chain_valid[s][k]),
                .in_ready     (chain_ready[s][k]),
                .out_data     (chain_data[s][k+1]),
                .out_tag      (chain_tag[s][k+1]),
                .out_keep     (chain_keep[s][k+1]),
                .out_last     (chain_last[s][k+1]),
                .out_valid    (chain_valid[s][k+1]),
                .out_ready    (chain_ready[s][k+1])
            );
        end

        assign chain_ready[s][NUM_SKID_STAGES] = out_ready[s]; // sink back-pressure enters here

        assign out_data[s]  = chain_data[s][NUM_SKID_STAGES];
        assign out_tag[s]   = chain_tag[s][NUM_SKID_STAGES];
        assign out_keep[s]  = chain_keep[s][NUM_SKID_STAGES];
        assign out_last[s]  = chain_last[s][NUM_SKID_STAGES];
        assign out_valid[s] = chain_valid[s][NUM_SKID_STAGES];
    end

endmodule

// File: hdl/tag_filter.sv
`include "tagged_stream_macros.svh"

module tag_filter (
    input  logic                          in_valid,
    input  tagged_stream_pkg::tag_t       in_tag,
    output logic                          in_ready,

    input  logic [(1 << `TAG_WIDTH)-1:0]  accept_mask,

    output logic                          out_valid,
    input  logic                          out_ready
);

    // high when this output subscribes to the element's tag
    logic tag_hit;

    assign tag_hit = accept_mask[in_tag];

    // a rejected element never reaches the skid chain
    assign out_valid = in_valid & tag_hit;

    // rejected elements are acknowledged at once, so the duplicator sees this
    // output as done and the element is dropped here
    assign in_ready = tag_hit ? out_ready : 1'b1;

endmodule

// File: hdl/tagged_duplicator.sv
`include "tagged_stream_macros.svh"

module tagged_duplicator #(
    parameter int NUM_STREAMS = `NUM_STREAMS
) (
    input  logic                   clk,
    input  logic                   reset_synced,

    input  logic                   in_valid,
    output logic                   in_ready,

    output logic [NUM_STREAMS-1:0] dup_valid,
    input  logic [NUM_STREAMS-1:0] dup_ready
);

    // one bit per output, set once that output has taken the current element
    logic [NUM_STREAMS-1:0] seen;
    logic [NUM_STREAMS-1:0] seen_next;
    logic [NUM_STREAMS-1:0] done;
    logic                   in_xfer;

    // an output is done if it took the element earlier or takes it now
    assign done = seen | dup_ready;

    // the input only moves on when every copy has been delivered
    assign in_ready = &done;
    assign in_xfer  = in_valid & in_ready;

    // outputs that already have the element must not see it again
    assign dup_valid = {NUM_STREAMS{in_valid}} & ~seen;

    always_comb begin
        seen_next = seen;

        if (in_xfer) begin
            seen_next = '0; // element complete, next one starts fresh
        end else if (in_valid) begin
            seen_next = done; // remember partial progress across stalled cycles
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            seen <= '0;
        end else begin
            seen <= seen_next;
        end
    end

endmodule

// File: hdl/tagged_skid_buffer.sv
`include "tagged_stream_macros.svh"

module tagged_skid_buffer (
    input  logic                     clk,
    input  logic                     reset_synced,

    input  tagged_stream_pkg::data_t in_data,
    input  tagged_stream_pkg::tag_t  in_tag,
    input  tagged_stream_pkg::keep_t in_keep,
    input  logic                     in_last,
    input  logic                     in_valid,
    output logic                     in_ready,

    output tagged_stream_pkg::data_t out_data,
    output tagged_stream_pkg::tag_t  out_tag,
    output tagged_stream_pkg::keep_t out_keep,
    output logic                     out_last,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import tagged_stream_pkg::*;

    skid_state_t state;
    skid_state_t state_next;

    // main register, always the element presented downstream
    data_t main_data;
    tag_t  main_tag;
    keep_t main_keep;
    logic  main_last;

    // skid register catches the element that arrives while main is stuck
    data_t skid_data;
    tag_t  skid_tag;
    keep_t skid_keep;
    logic  skid_last;

    logic in_xfer;
    logic out_xfer;
    logic load_main_in;   // main takes the incoming element
    logic load_main_skid; // main takes the parked skid element
    logic load_skid;      // skid takes the incoming element

    // ready is decoded from the state register only, which breaks the
    // combinational ready path between neighbouring stages
    assign in_ready  = (state != SKID_TWO);
    assign out_valid = (state != SKID_EMPTY);

    assign in_xfer  = in_valid & in_ready;
    assign out_xfer = out_valid & out_ready;

    always_comb begin
        state_next     = state;
        load_main_in   = 1'b0;
        load_main_skid = 1'b0;
        load_skid      = 1'b0;

        case (state)
            SKID_EMPTY: begin
                if (in_xfer) begin
                    load_main_in = 1'b1;
                    state_next   = SKID_ONE;
                end
            end
            SKID_ONE: begin
                if (in_xfer && out_xfer) begin
                    load_main_in = 1'b1; // pass-through, level stays at one
                end else if (in_xfer) begin
                    load_skid  = 1'b1;
                    state_next = SKID_TWO;
                end else if (out_xfer) begin
                    state_next = SKID_EMPTY;
                end
            end
            SKID_TWO: begin
                // in_ready is low here, only the drain side can move
                if (out_xfer) begin
                    load_main_skid = 1'b1;
                    state_next     = SKID_ONE;
                end
            end
            default: begin
                state_next = SKID_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_synced) begin
            state <= SKID_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_main_in) begin
            main_data <= in_data;
            main_tag  <= in_tag;
            main_keep <= in_keep;
            main_last <= in_last;
        end else if (load_main_skid) begin
            main_data <= skid_data;
            main_tag  <= skid_tag;
            main_keep <= skid_keep;
            main_last <= skid_last;
        end

        if (load_skid) begin
            skid_data <= in_data;
            skid_tag  <= in_tag;
            skid_keep <= in_keep;
            skid_last <= in_last;
        end
    end

    assign out_data = main_data;
    assign out_tag  = main_tag;
    assign out_keep = main_keep;
    assign out_last = main_last;

endmodule

// File: hdl/tagged_stream_pkg.sv
`include "tagged_stream_macros.svh"

package tagged_stream_pkg;

    // payload fields of one stream element
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`TAG_WIDTH-1:0]  tag_t;
    typedef logic [`KEEP_WIDTH-1:0] keep_t;

    // fill level of a two-entry skid buffer
    typedef enum logic [1:0] {
        SKID_EMPTY = 2'd0, // nothing held, output idle
        SKID_ONE   = 2'd1, // main register holds the head element
        SKID_TWO   = 2'd2  // main and skid registers both full
    } skid_state_t;

endpackage

// File: hdl/tagged_stream_macros.svh
`ifndef TAGGED_STREAM_MACROS_SVH
`define TAGGED_STREAM_MACROS_SVH

// width of one data word on every stream
`define DATA_WIDTH 32

// three tag bits give eight tag values, one accept mask bit each
`define TAG_WIDTH 3

// one byte enable per data byte
`define KEEP_WIDTH (`DATA_WIDTH / 8)

// default number of fan-out outputs
`define NUM_STREAMS 3

// default number of skid buffers in each output chain
`define NUM_SKID_STAGES 2

`endif
